/* Makefile */
# Verilator build and regression run for the ooo core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module ooo_core_tb \
		-Mdir obj_dir -o sim_ooo_core

run: compile
	./obj_dir/sim_ooo_core | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* logic/exec_unit.sv */
// execute unit, single-cycle alu plus an iterative multiplier
// the result register is the only driver of the common data bus
`timescale 1ns/1ps
`default_nettype none

`include "ooo_params.svh"

module exec_unit (
	input  logic            clock,
	input  logic            rst_n,
	input  logic            issue_valid,
	input  ooo_pkg::issue_t issue,
	output logic            fu_busy,
	output ooo_pkg::cdb_t   cdb
);

	localparam int STEP_W  = `OOO_DATA_W / `OOO_MUL_CYCLES;  // multiplier bits per cycle
	localparam int SHAMT_W = $clog2(`OOO_DATA_W);
	localparam int CNT_W   = $clog2(`OOO_MUL_CYCLES + 1);

	ooo_pkg::data_t     alu_res;
	ooo_pkg::data_t     acc_q;
	ooo_pkg::data_t     mcand_q;
	ooo_pkg::data_t     mplier_q;
	ooo_pkg::data_t     acc_in;
	ooo_pkg::data_t     mcand_in;
	ooo_pkg::data_t     mplier_in;
	ooo_pkg::data_t     acc_next;
	ooo_pkg::phys_idx_t mul_tag;
	ooo_pkg::rob_idx_t  mul_rob;
	logic [CNT_W-1:0]   mul_left;   // steps still to run after this one
	logic               mul_start;

	assign mul_start = issue_valid && issue.func == ooo_pkg::alu_mul;
	// last step frees the unit, a new op issued then lands on the bus a cycle later
	assign fu_busy = mul_start || mul_left > CNT_W'(1);

	always_comb begin
		case (issue.func)
			ooo_pkg::alu_sub: alu_res = issue.opa - issue.opb;
			ooo_pkg::alu_and: alu_res = issue.opa & issue.opb;
			ooo_pkg::alu_or:  alu_res = issue.opa | issue.opb;
			ooo_pkg::alu_xor: alu_res = issue.opa ^ issue.opb;
			ooo_pkg::alu_shl: alu_res = issue.opa << issue.opb[SHAMT_W-1:0];
			default:          alu_res = issue.opa + issue.opb;  // add
		endcase
	end

	////////////////////////////////
	// shift-add multiplier step
	////////////////////////////////
	assign acc_in    = mul_start ? '0 : acc_q;           // first step runs off the issue reg
	assign mcand_in  = mul_start ? issue.opa : mcand_q;
	assign mplier_in = mul_start ? issue.opb : mplier_q;
	assign acc_next  = acc_in + mcand_in * ooo_pkg::data_t'(mplier_in[STEP_W-1:0]);

	always_ff @(posedge clock) begin
		acc_q    <= acc_next;
		mcand_q  <= mcand_in << STEP_W;
		mplier_q <= mplier_in >> STEP_W;
		if (mul_start) begin
			mul_tag <= issue.phys_dest;
			mul_rob <= issue.rob_slot;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			cdb      <= '0;
			mul_left <= '0;
		end else begin
			cdb.valid <= 1'b0;  // one cycle per result
			if (issue_valid && !mul_start) begin
				cdb <= '{valid: 1'b1, tag: issue.phys_dest, rob_slot: issue.rob_slot,
					value: alu_res};
			end
			if (mul_start) begin
				mul_left <= CNT_W'(`OOO_MUL_CYCLES - 1);
			end else if (mul_left != '0) begin
				mul_left <= mul_left - 1'b1;
				if (mul_left == CNT_W'(1)) begin
					cdb <= '{valid: 1'b1, tag: mul_tag, rob_slot: mul_rob, value: acc_next};
				end
			end
		end
	end

endmodule

`default_nettype wire

/* logic/ooo_core.sv */
// out-of-order integer core, rename to reservation station to execute to in-order commit
// one dispatch per cycle, held off by the stall level
`timescale 1ns/1ps
`default_nettype none

module ooo_core (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               dispatch_valid,
	input  ooo_pkg::dispatch_t dispatch,
	output logic               stall,
	output logic               commit_valid,
	output ooo_pkg::commit_t   commit
);

	ooo_pkg::rename_t   rename;
	ooo_pkg::data_t     val_a;
	ooo_pkg::data_t     val_b;
	ooo_pkg::data_t     head_value;
	ooo_pkg::phys_idx_t head_phys;
	ooo_pkg::phys_idx_t commit_stale;
	ooo_pkg::rob_idx_t  rob_slot;
	ooo_pkg::cdb_t      cdb;
	ooo_pkg::issue_t    issue;
	logic               rdy_a;
	logic               rdy_b;
	logic               issue_valid;
	logic               fu_busy;
	logic               rs_full;
	logic               rob_full;
	logic               free_empty;
	logic               accept;

	// free list only matters when the instruction writes a reg
	assign stall  = rob_full | rs_full | (free_empty & rename.has_dest);
	assign accept = dispatch_valid & ~stall;

	////////////////////////////////
	// rename and operand read
	////////////////////////////////
	rename_map i_rename_map (
		.clock           (clock),
		.rst_n           (rst_n),
		.accept          (accept),
		.dispatch        (dispatch),
		.retire_valid    (commit_valid),
		.retire_stale    (commit_stale),
		.retire_has_dest (commit.has_dest),
		.rename          (rename),
		.free_empty      (free_empty)
	);

	phys_regfile i_phys_regfile (
		.clock       (clock),
		.rst_n       (rst_n),
		.alloc_valid (accept & rename.has_dest),
		.alloc_tag   (rename.phys_dest),
		.rd_a        (rename.phys_a),
		.rd_b        (rename.phys_b),
		.val_a       (val_a),
		.val_b       (val_b),
		.rdy_a       (rdy_a),
		.rdy_b       (rdy_b),
		.rd_commit   (head_phys),
		.val_commit  (head_value),
		.cdb         (cdb)
	);

	////////////////////////////////
	// schedule and execute
	////////////////////////////////
	res_station i_res_station (
		.clock       (clock),
		.rst_n       (rst_n),
		.capture     (accept),
		.dispatch    (dispatch),
		.rename      (rename),
		.val_a       (val_a),
		.val_b       (val_b),
		.rdy_a       (rdy_a),
		.rdy_b       (rdy_b),
		.rob_slot    (rob_slot),
		.cdb         (cdb),
		.fu_busy     (fu_busy),
		.issue_valid (issue_valid),
		.issue       (issue),
		.rs_full     (rs_full)
	);

	exec_unit i_exec_unit (
		.clock       (clock),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue       (issue),
		.fu_busy     (fu_busy),
		.cdb         (cdb)
	);

	////////////////////////////////
	// in-order commit
	////////////////////////////////
	reorder_buf i_reorder_buf (
		.clock        (clock),
		.rst_n        (rst_n),
		.alloc        (accept),
		.dispatch     (dispatch),
		.rename       (rename),
		.alloc_slot   (rob_slot),
		.rob_full     (rob_full),
		.cdb          (cdb),
		.head_phys    (head_phys),
		.head_value   (head_value),
		.commit_valid (commit_valid),
		.commit       (commit),
		.commit_stale (commit_stale)
	);

endmodule

`default_nettype wire

/* logic/ooo_params.svh */
// ooo core sizing
// widths, queue depths and multiply latency shared by the rtl
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// datapath
`define OOO_DATA_W      32      // operand and result width

// register files
`define OOO_ARCH_REGS   8       // architectural regs, r0 is never written
`define OOO_PHYS_REGS   16      // physical regs behind the alias table

// queues
`define OOO_ROB_DEPTH   8       // reorder buffer slots
`define OOO_RS_DEPTH    4       // reservation station entries

// execute
`define OOO_MUL_CYCLES  4       // cycles from multiply issue to bus

`endif

/* logic/ooo_pkg.sv */
// ooo core shared types
// operand and index widths, alu functions and the structs passed between stages
`include "ooo_params.svh"

`default_nettype none

package ooo_pkg;

	typedef logic [`OOO_DATA_W-1:0]                data_t;     // operand or result word
	typedef logic [$clog2(`OOO_ARCH_REGS)-1:0]     arch_idx_t; // architectural reg index
	typedef logic [$clog2(`OOO_PHYS_REGS)-1:0]     phys_idx_t; // physical reg index, also the bus tag
	typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0]     rob_idx_t;  // reorder buffer slot

	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_xor = 3'd4,
		alu_shl = 3'd5,
		alu_mul = 3'd6     // the only multi-cycle function
	} alu_func_e;

	// decoded instruction as it enters rename
	typedef struct packed {
		data_t     pc;
		alu_func_e func;
		arch_idx_t src_a;
		arch_idx_t src_b;
		logic      use_imm;  // imm replaces operand b
		data_t     imm;
		arch_idx_t dest;     // zero means no writeback
	} dispatch_t;

	typedef struct packed {
		phys_idx_t phys_a;
		phys_idx_t phys_b;
		phys_idx_t phys_dest;  // new mapping, zero without a dest
		phys_idx_t stale_dest; // previous mapping, freed at commit
		logic      has_dest;
	} rename_t;

	typedef struct packed {
		alu_func_e func;
		data_t     opa;
		data_t     opb;
		phys_idx_t phys_dest;
		rob_idx_t  rob_slot;
	} issue_t;

	// common data bus, one writer
	typedef struct packed {
		logic      valid;
		phys_idx_t tag;
		rob_idx_t  rob_slot;
		data_t     value;
	} cdb_t;

	typedef struct packed {
		data_t     pc;
		arch_idx_t arch_dest;
		phys_idx_t phys_dest;
		data_t     value;
		logic      has_dest;
	} commit_t;

endpackage

`default_nettype wire

/* logic/phys_regfile.sv */
// physical register file with one ready bit per register
// two operand reads and a commit read, written only from the common data bus
`timescale 1ns/1ps
`default_nettype none

`include "ooo_params.svh"

module phys_regfile (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               alloc_valid,  // new dest handed out by rename
	input  ooo_pkg::phys_idx_t alloc_tag,
	input  ooo_pkg::phys_idx_t rd_a,
	input  ooo_pkg::phys_idx_t rd_b,
	output ooo_pkg::data_t     val_a,
	output ooo_pkg::data_t     val_b,
	output logic               rdy_a,
	output logic               rdy_b,
	input  ooo_pkg::phys_idx_t rd_commit,    // rob head dest
	output ooo_pkg::data_t     val_commit,
	input  ooo_pkg::cdb_t      cdb
);

	ooo_pkg::data_t            regs [`OOO_PHYS_REGS];
	logic [`OOO_PHYS_REGS-1:0] ready;

	assign val_a      = regs[rd_a];
	assign val_b      = regs[rd_b];
	assign rdy_a      = ready[rd_a];
	assign rdy_b      = ready[rd_b];
	assign val_commit = regs[rd_commit];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `OOO_PHYS_REGS; i++) begin
				regs[i]  <= '0;
				ready[i] <= i < `OOO_ARCH_REGS;  // only the identity mapped regs
			end
		end else begin
			// phys 0 backs r0 and stays zero, no-dest results land nowhere
			if (cdb.valid && cdb.tag != '0) begin
				regs[cdb.tag]  <= cdb.value;
				ready[cdb.tag] <= 1'b1;
			end
			if (alloc_valid) begin
				ready[alloc_tag] <= 1'b0;  // value pending until broadcast
			end
		end
	end

endmodule

`default_nettype wire

/* logic/rename_map.sv */
// register alias table with a circular free list of physical registers
// lookup is combinational, table and free list move on an accepted dispatch or a commit
`timescale 1ns/1ps
`default_nettype none

`include "ooo_params.svh"

module rename_map (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                accept,          // dispatch taken this cycle
	input  ooo_pkg::dispatch_t  dispatch,
	input  logic                retire_valid,    // head of rob commits
	input  ooo_pkg::phys_idx_t  retire_stale,
	input  logic                retire_has_dest,
	output ooo_pkg::rename_t    rename,
	output logic                free_empty
);

	localparam int FREE_INIT = `OOO_PHYS_REGS - `OOO_ARCH_REGS; // regs not mapped at reset
	localparam int CNT_W     = $clog2(`OOO_PHYS_REGS + 1);

	ooo_pkg::phys_idx_t alias_tbl [`OOO_ARCH_REGS];  // arch -> phys
	ooo_pkg::phys_idx_t free_fifo [`OOO_PHYS_REGS];  // circular, wraps with the index width
	ooo_pkg::phys_idx_t free_rd;
	ooo_pkg::phys_idx_t free_wr;
	logic [CNT_W-1:0]   free_cnt;
	logic               has_dest;
	logic               free_pop;
	logic               free_push;

	////////////////////////////////
	// lookup
	////////////////////////////////
	assign has_dest = dispatch.dest != '0;

	assign rename.phys_a     = alias_tbl[dispatch.src_a];
	assign rename.phys_b     = alias_tbl[dispatch.src_b];
	assign rename.phys_dest  = has_dest ? free_fifo[free_rd] : '0; // phys 0 for no writeback
	assign rename.stale_dest = alias_tbl[dispatch.dest];
	assign rename.has_dest   = has_dest;

	assign free_empty = free_cnt == '0;
	assign free_pop   = accept && has_dest;
	assign free_push  = retire_valid && retire_has_dest; // stale reg comes back

	////////////////////////////////
	// table and free list
	////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
				alias_tbl[i] <= ooo_pkg::phys_idx_t'(i);  // identity map
			end
			// first FREE_INIT slots hold the unmapped regs, the rest is don't care
			for (int i = 0; i < `OOO_PHYS_REGS; i++) begin
				free_fifo[i] <= ooo_pkg::phys_idx_t'(i + `OOO_ARCH_REGS);
			end
			free_rd  <= '0;
			free_wr  <= ooo_pkg::phys_idx_t'(FREE_INIT);
			free_cnt <= CNT_W'(FREE_INIT);
		end else begin
			if (free_pop) begin
				alias_tbl[dispatch.dest] <= free_fifo[free_rd];
				free_rd                  <= free_rd + 1'b1;
			end
			if (free_push) begin
				free_fifo[free_wr] <= retire_stale;
				free_wr            <= free_wr + 1'b1;
			end
			free_cnt <= free_cnt + CNT_W'(free_push) - CNT_W'(free_pop);
		end
	end

endmodule

`default_nettype wire

/* logic/reorder_buf.sv */
// circular reorder buffer, marks slots done from the bus and commits in order
`timescale 1ns/1ps
`default_nettype none

`include "ooo_params.svh"

module reorder_buf (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               alloc,        // accepted dispatch takes the tail
	input  ooo_pkg::dispatch_t dispatch,
	input  ooo_pkg::rename_t   rename,
	output ooo_pkg::rob_idx_t  alloc_slot,
	output logic               rob_full,
	input  ooo_pkg::cdb_t      cdb,
	output ooo_pkg::phys_idx_t head_phys,    // to the commit read port
	input  ooo_pkg::data_t     head_value,
	output logic               commit_valid,
	output ooo_pkg::commit_t   commit,
	output ooo_pkg::phys_idx_t commit_stale
);

	localparam int CNT_W = $clog2(`OOO_ROB_DEPTH + 1);

	typedef struct packed {
		ooo_pkg::data_t     pc;
		ooo_pkg::arch_idx_t arch_dest;
		ooo_pkg::phys_idx_t phys_dest;
		ooo_pkg::phys_idx_t stale_dest;
		logic               has_dest;
	} rob_entry_t;

	rob_entry_t                slots [`OOO_ROB_DEPTH];
	rob_entry_t                head_entry;
	logic [`OOO_ROB_DEPTH-1:0] done;
	ooo_pkg::rob_idx_t         head;
	ooo_pkg::rob_idx_t         tail;
	logic [CNT_W-1:0]          count;

	assign head_entry   = slots[head];
	assign alloc_slot   = tail;
	assign rob_full     = count == CNT_W'(`OOO_ROB_DEPTH);
	assign head_phys    = head_entry.phys_dest;
	assign commit_valid = done[head];   // done is only ever set on a live slot
	assign commit_stale = head_entry.stale_dest;
	assign commit       = '{pc: head_entry.pc, arch_dest: head_entry.arch_dest,
		phys_dest: head_entry.phys_dest, value: head_value, has_dest: head_entry.has_dest};

	always_ff @(posedge clock) begin
		if (alloc) begin
			slots[tail] <= '{pc: dispatch.pc, arch_dest: dispatch.dest,
				phys_dest: rename.phys_dest, stale_dest: rename.stale_dest,
				has_dest: rename.has_dest};
		end
	end

	////////////////////////////////
	// pointers and done bits
	////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			done  <= '0;
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (cdb.valid) begin
				done[cdb.rob_slot] <= 1'b1;
			end
			if (alloc) begin
				done[tail] <= 1'b0;
				tail       <= tail + 1'b1;
			end
			if (commit_valid) begin
				done[head] <= 1'b0;
				head       <= head + 1'b1;
			end
			count <= count + CNT_W'(alloc) - CNT_W'(commit_valid);
		end
	end

endmodule

`default_nettype wire

/* logic/res_station.sv */
// reservation station, holds renamed instructions until both operands arrive
// snoops the bus for wakeup and issues the lowest ready entry into a register
`timescale 1ns/1ps
`default_nettype none

`include "ooo_params.svh"

module res_station (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               capture,     // accepted dispatch
	input  ooo_pkg::dispatch_t dispatch,
	input  ooo_pkg::rename_t   rename,
	input  ooo_pkg::data_t     val_a,
	input  ooo_pkg::data_t     val_b,
	input  logic               rdy_a,
	input  logic               rdy_b,
	input  ooo_pkg::rob_idx_t  rob_slot,
	input  ooo_pkg::cdb_t      cdb,
	input  logic               fu_busy,
	output logic               issue_valid,
	output ooo_pkg::issue_t    issue,
	output logic               rs_full
);

	localparam int IDX_W = $clog2(`OOO_RS_DEPTH);

	typedef struct packed {
		ooo_pkg::alu_func_e func;
		logic               rdy_a;
		logic               rdy_b;
		ooo_pkg::phys_idx_t tag_a;     // producer when not ready
		ooo_pkg::phys_idx_t tag_b;
		ooo_pkg::data_t     opa;
		ooo_pkg::data_t     opb;
		ooo_pkg::phys_idx_t phys_dest;
		ooo_pkg::rob_idx_t  rob_slot;
	} rs_entry_t;

	rs_entry_t                 ent_q [`OOO_RS_DEPTH];
	rs_entry_t                 ent_d [`OOO_RS_DEPTH];
	rs_entry_t                 incoming;
	logic [`OOO_RS_DEPTH-1:0]  busy_q;
	logic [`OOO_RS_DEPTH-1:0]  busy_d;
	logic [IDX_W-1:0]          free_slot;
	logic [IDX_W-1:0]          pick;
	logic                      pick_ok;

	// take a broadcast value for any operand still waiting on its tag
	function automatic rs_entry_t snoop(input rs_entry_t e, input ooo_pkg::cdb_t c);
		rs_entry_t r;
		r = e;
		if (c.valid && !e.rdy_a && e.tag_a == c.tag) begin
			r.rdy_a = 1'b1;
			r.opa   = c.value;
		end
		if (c.valid && !e.rdy_b && e.tag_b == c.tag) begin
			r.rdy_b = 1'b1;
			r.opb   = c.value;
		end
		return r;
	endfunction

	assign rs_full = &busy_q;

	always_comb begin
		incoming.func      = dispatch.func;
		incoming.tag_a     = rename.phys_a;
		incoming.tag_b     = rename.phys_b;
		incoming.rdy_a     = rdy_a;
		incoming.opa       = val_a;
		incoming.rdy_b     = dispatch.use_imm | rdy_b;          // imm is always ready
		incoming.opb       = dispatch.use_imm ? dispatch.imm : val_b;
		incoming.phys_dest = rename.phys_dest;
		incoming.rob_slot  = rob_slot;
	end

	////////////////////////////////
	// next state and issue pick
	////////////////////////////////
	always_comb begin
		busy_d    = busy_q;
		free_slot = '0;
		pick      = '0;
		pick_ok   = 1'b0;
		for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
			ent_d[i] = snoop(ent_q[i], cdb);
		end
		for (int i = `OOO_RS_DEPTH - 1; i >= 0; i--) begin
			if (!busy_q[i]) begin
				free_slot = IDX_W'(i);  // lowest empty slot
			end
		end
		if (capture) begin
			ent_d[free_slot]  = snoop(incoming, cdb);  // same-cycle broadcast counts
			busy_d[free_slot] = 1'b1;
		end
		for (int i = `OOO_RS_DEPTH - 1; i >= 0; i--) begin
			if (!fu_busy && busy_d[i] && ent_d[i].rdy_a && ent_d[i].rdy_b) begin
				pick    = IDX_W'(i);   // lowest index wins
				pick_ok = 1'b1;
			end
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy_q      <= '0;
			issue_valid <= 1'b0;
		end else begin
			busy_q <= busy_d;
			if (pick_ok) begin
				busy_q[pick] <= 1'b0;
			end
			issue_valid <= pick_ok;
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
			ent_q[i] <= ent_d[i];
		end
		issue <= '{func: ent_d[pick].func, opa: ent_d[pick].opa, opb: ent_d[pick].opb,
			phys_dest: ent_d[pick].phys_dest, rob_slot: ent_d[pick].rob_slot};
	end

endmodule

`default_nettype wire

/* sim/ooo_core_tb.sv */
// testbench for the ooo core
// lfsr stimulus, architectural golden model and in-order commit checks
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb;

	localparam int MAX_CYCLES = 400 * 8 + 800;  // 400 instr at 8 cycles each plus margin

	logic               clock;
	logic               rst_n;
	logic               dispatch_valid;
	ooo_pkg::dispatch_t dispatch;
	logic               stall;
	logic               commit_valid;
	ooo_pkg::commit_t   commit;

	ooo_pkg::data_t     arch_regs [8];  // architectural state in program order
	ooo_pkg::commit_t   exp_q [$];      // expected commits, oldest first
	ooo_pkg::commit_t   head_exp;
	ooo_pkg::data_t     opb_val;
	ooo_pkg::data_t     result;
	ooo_pkg::data_t     next_pc;
	logic [31:0]        lfsr;
	int                 accept_count;
	int                 commit_count;
	int                 nodest_commits;
	int                 stall_hits;     // cycles an offer was held off
	int                 errors;
	int                 test_base;
	int                 tests_run;
	int                 cycles;

	ooo_core i_ooo_core (
		.clock          (clock),
		.rst_n          (rst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch       (dispatch),
		.stall          (stall),
		.commit_valid   (commit_valid),
		.commit         (commit)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;  // 40 ns period
	end

	//////////////////////////////
	// helpers
	//////////////////////////////
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois, right shift
	endfunction

	// one lfsr step per bit taken
	task automatic draw(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	// architectural result of one function
	function automatic ooo_pkg::data_t model_alu(input ooo_pkg::alu_func_e f,
		input ooo_pkg::data_t a, input ooo_pkg::data_t b);
		logic [63:0] prod;
		prod = {32'd0, a} * {32'd0, b};
		case (f)
			ooo_pkg::alu_add: return a + b;
			ooo_pkg::alu_sub: return a - b;
			ooo_pkg::alu_and: return a & b;
			ooo_pkg::alu_or:  return a | b;
			ooo_pkg::alu_xor: return a ^ b;
			ooo_pkg::alu_shl: return a << b[4:0];  // low 5 bits only
			ooo_pkg::alu_mul: return prod[31:0];   // low half of the product
			default:          return '0;
		endcase
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
		errors++;
	endtask

	// called on a falling edge, holds the offer until the core takes it
	task automatic send(input ooo_pkg::alu_func_e f, input ooo_pkg::arch_idx_t sa,
		input ooo_pkg::arch_idx_t sb, input logic ui, input ooo_pkg::data_t im,
		input ooo_pkg::arch_idx_t d);
		int target;
		target         = accept_count + 1;
		dispatch       = '{pc: next_pc, func: f, src_a: sa, src_b: sb, use_imm: ui,
			imm: im, dest: d};
		dispatch_valid = 1'b1;
		@(negedge clock);
		while (accept_count < target) begin
			@(negedge clock);  // stalled, keep holding
		end
		dispatch_valid = 1'b0;
		next_pc        = next_pc + 32'd4;
	endtask

	task automatic load_reg(input ooo_pkg::arch_idx_t d, input ooo_pkg::data_t v);
		send(ooo_pkg::alu_add, 3'd0, 3'd0, 1'b1, v, d);  // r0 + imm
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clock);
	endtask

	task automatic drain;
		while (exp_q.size() != 0) begin
			@(negedge clock);
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		$display("test %-12s done, %0d errors", name, errors - test_base);
		test_base = errors;
	endtask

	//////////////////////////////
	// golden model and checks
	//////////////////////////////
	always @(posedge clock) begin
		if (rst_n) begin
			if (commit_valid) begin
				commit_count++;
				assert (exp_q.size() != 0) else begin
					$display("commit of pc %h at %0t with nothing outstanding", commit.pc, $time);
					errors++;
				end
				if (exp_q.size() != 0) begin
					head_exp = exp_q.pop_front();
					assert (commit.pc == head_exp.pc) else
						report_mismatch("commit pc", commit.pc, head_exp.pc);
					assert (commit.has_dest == head_exp.has_dest) else
						report_mismatch("has_dest", 32'(commit.has_dest), 32'(head_exp.has_dest));
					if (head_exp.has_dest) begin
						assert (commit.arch_dest == head_exp.arch_dest) else
							report_mismatch("arch dest", 32'(commit.arch_dest),
								32'(head_exp.arch_dest));
						assert (commit.value == head_exp.value) else
							report_mismatch("commit value", commit.value, head_exp.value);
						assert (commit.phys_dest != '0) else begin
							$display("[FAIL] %0t: commit of pc %h writes back through phys reg 0",
								$time, commit.pc);
							errors++;
						end
					end
				end
				if (!commit.has_dest) begin
					nodest_commits++;
				end
			end
			if (dispatch_valid && stall) begin
				stall_hits++;
			end
			if (dispatch_valid && !stall) begin
				opb_val = dispatch.use_imm ? dispatch.imm : arch_regs[dispatch.src_b];
				result  = model_alu(dispatch.func, arch_regs[dispatch.src_a], opb_val);
				exp_q.push_back('{pc: dispatch.pc, arch_dest: dispatch.dest, phys_dest: '0,
					value: result, has_dest: dispatch.dest != 3'd0});
				if (dispatch.dest != 3'd0) begin
					arch_regs[dispatch.dest] = result;
				end
				accept_count++;
			end
		end
	end

	//////////////////////////////
	// tests
	//////////////////////////////
	task automatic test_reset;
		assert (stall == 1'b0 && commit_valid == 1'b0) else begin
			$display("[FAIL] %0t: stall or commit_valid high after reset", $time);
			errors++;
		end
		send(ooo_pkg::alu_add, 3'd2, 3'd3, 1'b0, '0, 3'd1);  // all regs start at zero
		drain();
		end_test("reset");
	endtask

	task automatic test_functions;
		logic [31:0] v;
		ooo_pkg::alu_func_e f;
		draw(32, v);
		load_reg(3'd1, v);
		draw(32, v);
		load_reg(3'd2, v);
		for (int i = 0; i < 7; i++) begin
			f = ooo_pkg::alu_func_e'(i);
			send(f, 3'd1, 3'd2, 1'b0, '0, 3'd3);  // register operands
			draw(32, v);
			send(f, 3'd1, 3'd0, 1'b1, v, 3'd4);   // immediate operand
		end
		drain();
		end_test("functions");
	endtask

	task automatic test_chain;
		logic [31:0] v;
		ooo_pkg::arch_idx_t prev;
		ooo_pkg::arch_idx_t d;
		draw(32, v);
		load_reg(3'd1, v);
		draw(32, v);
		load_reg(3'd5, v);  // shared second operand
		prev = 3'd1;
		for (int i = 0; i < 10; i++) begin
			draw(3, v);
			d = (i % 2 == 0) ? 3'd2 : 3'd1;  // each reads the last one's dest
			if (v[2:0] == 3'd7) begin
				v[2:0] = 3'd6;
			end
			send(ooo_pkg::alu_func_e'(v[2:0]), prev, 3'd5, i % 3 == 0, 32'h13 + 32'(i), d);
			prev = d;
		end
		drain();
		end_test("chain");
	endtask

	task automatic test_commit_order;
		send(ooo_pkg::alu_mul, 3'd1, 3'd2, 1'b0, '0, 3'd6);  // slow head
		send(ooo_pkg::alu_add, 3'd6, 3'd0, 1'b1, 32'd7, 3'd5);  // waits on the multiply
		send(ooo_pkg::alu_xor, 3'd4, 3'd3, 1'b0, '0, 3'd7);
		send(ooo_pkg::alu_or, 3'd2, 3'd0, 1'b1, 32'hf0, 3'd3);
		drain();
		end_test("commit_order");
	endtask

	task automatic test_mul_burst;
		int hits_before;
		hits_before = stall_hits;
		for (int i = 0; i < 8; i++) begin
			send(ooo_pkg::alu_mul, 3'd1, 3'd2, 1'b0, '0, ooo_pkg::arch_idx_t'(3 + i % 5));
		end
		drain();
		assert (stall_hits > hits_before) else begin
			$display("[FAIL] %0t: stall never rose during the multiply burst", $time);
			errors++;
		end
		end_test("mul_burst");
	endtask

	task automatic test_random;
		logic [31:0] fb;
		logic [31:0] sa;
		logic [31:0] sb;
		logic [31:0] ui;
		logic [31:0] im;
		logic [31:0] d;
		logic [31:0] gap;
		int          nodest_before;
		nodest_before = nodest_commits;
		for (int i = 0; i < 300; i++) begin
			draw(3, fb);
			draw(3, sa);
			draw(3, sb);
			draw(1, ui);
			draw(32, im);
			draw(3, d);  // dest 0 about one time in eight
			if (fb[2:0] == 3'd7) begin
				fb[2:0] = 3'd0;
			end
			send(ooo_pkg::alu_func_e'(fb[2:0]), sa[2:0], sb[2:0], ui[0], im, d[2:0]);
			draw(2, gap);
			if (gap[1:0] == 2'd0) begin
				draw(2, gap);
				idle(int'(gap[1:0]) + 1);
			end
		end
		drain();
		assert (nodest_commits > nodest_before) else begin
			$display("[FAIL] %0t: no commit without a destination in the random run", $time);
			errors++;
		end
		end_test("random");
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial begin
		rst_n          = 1'b0;
		dispatch_valid = 1'b0;
		dispatch       = '0;
		next_pc        = 32'h0000_1000;
		lfsr           = 32'h3b79;
		accept_count   = 0;
		commit_count   = 0;
		nodest_commits = 0;
		stall_hits     = 0;
		errors         = 0;
		test_base      = 0;
		tests_run      = 0;
		for (int r = 0; r < 8; r++) begin
			arch_regs[r] = '0;
		end
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		test_reset();
		test_functions();
		test_chain();
		test_commit_order();
		test_mul_burst();
		test_random();
		idle(2);
		$display("tests %0d, accepted %0d, committed %0d, errors %0d", tests_run,
			accept_count, commit_count, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout after %0d cycles with %0d commits outstanding", cycles, exp_q.size());
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/ooo_pkg.sv
logic/rename_map.sv
logic/phys_regfile.sv
logic/res_station.sv
logic/exec_unit.sv
logic/reorder_buf.sv
logic/ooo_core.sv
sim/ooo_core_tb.sv
